//--- rate_monitor_pkg.sv
// ********************
// Rate monitor package
// Widths, vector types, window length and FSM state encoding
// ********************

package rate_monitor_pkg;

  // Published count width, the count tops out at 63
  localparam int RATE_WIDTH = 6;

  // Length of one measurement window in in_clk cycles
  localparam int WINDOW_CYCLES = 64;

  // Wide enough to hold WINDOW_CYCLES-1
  localparam int TIMER_WIDTH = 7;

  // Event count for one window
  typedef logic [RATE_WIDTH-1:0] rate_t;

  // Remaining cycles in the current window
  typedef logic [TIMER_WIDTH-1:0] timer_t;

  // Word that crosses into out_clk, saturation flag on top and count below it
  typedef logic [RATE_WIDTH:0] report_t;

  // Sequencer states of the monitor
  typedef enum logic [1:0] {
    st_idle,
    st_measure,
    st_publish
  } monitor_state_t;

endpackage

//--- sync_bits.sv
// ********************
// Two-stage synchronizer
// Carries slow levels into the destination clock domain
// ********************

`timescale 1ns/100ps

module sync_bits #(
  parameter int NUM_OF_BITS = 1
) (
  input  logic [NUM_OF_BITS-1:0] in,
  input  logic                   out_clk,
  input  logic                   out_reset,
  output logic [NUM_OF_BITS-1:0] out
);

  // First stage may go metastable, the second one settles it
  logic [NUM_OF_BITS-1:0] stage_meta;
  logic [NUM_OF_BITS-1:0] stage_sync;

  // Both stages run on the destination clock
  // Bits are independent, so only levels that change slowly are safe here
  always_ff @(posedge out_clk) begin
    if (out_reset) begin
      stage_meta <= '0;
      stage_sync <= '0;
    end else begin
      stage_meta <= in;
      stage_sync <= stage_meta;
    end
  end

  // Output is the second stage, two destination cycles after the input
  assign out = stage_sync;

endmodule

//--- sync_data.sv
// ********************
// Toggle-handshake crossing
// Moves a multi-bit word from in_clk into out_clk through a held copy
// ********************

`timescale 1ns/100ps

module sync_data #(
  parameter int NUM_OF_BITS = 1,
  parameter int ASYNC_CLK   = 1
) (
  input  logic                   in_clk,
  input  logic [NUM_OF_BITS-1:0] in_data,
  input  logic                   out_clk,
  input  logic                   out_reset,
  output logic [NUM_OF_BITS-1:0] out_data
);

  if (ASYNC_CLK == 1) begin : g_async

    // Request toggle in in_clk, starts from a known level
    logic                   in_toggle = 1'b0;
    // Acknowledge toggle as seen back in in_clk
    logic                   in_toggle_ack;
    // Request toggle as seen in out_clk
    logic                   out_toggle_sync;
    // Last request level taken by out_clk, this is the acknowledge
    logic                   out_toggle;
    // Copy of in_data that stays still while out_clk reads it
    logic [NUM_OF_BITS-1:0] cdc_hold;
    logic                   in_load;
    logic                   out_load;

    // Request path into out_clk, cleared with the out_clk domain
    sync_bits #(
      .NUM_OF_BITS(1)
    ) sync_out_i (
      .in        (in_toggle),
      .out_clk   (out_clk),
      .out_reset (out_reset),
      .out       (out_toggle_sync)
    );

    // Acknowledge path back into in_clk
    sync_bits #(
      .NUM_OF_BITS(1)
    ) sync_in_i (
      .in        (out_toggle),
      .out_clk   (in_clk),
      .out_reset (1'b0),
      .out       (in_toggle_ack)
    );

    // Loop is idle once the acknowledge has caught up with the request
    assign in_load = (in_toggle_ack == in_toggle);
    // Any change of the synchronized request means a fresh word waits
    assign out_load = out_toggle_sync ^ out_toggle;

    // Sample a new word and raise the next request in the same edge
    always_ff @(posedge in_clk) begin
      if (in_load) begin
        cdc_hold  <= in_data;
        in_toggle <= ~in_toggle;
      end
    end

    // The hold register has been still for at least two out_clk cycles here
    always_ff @(posedge out_clk) begin
      if (out_reset) begin
        out_toggle <= 1'b0;
        out_data   <= '0;
      end else begin
        out_toggle <= out_toggle_sync;
        if (out_load) begin
          out_data <= cdc_hold;
        end
      end
    end

  end else begin : g_bypass

    // Same clock on both sides, so the word passes straight through
    always_comb begin
      out_data = in_data;
    end

  end

endmodule

//--- window_timer.sv
// ********************
// Window timer
// Down-counter that marks the last cycle of each window
// ********************

`timescale 1ns/100ps

module window_timer (
  input  logic in_clk,
  input  logic reset,
  input  logic restart,
  input  logic run,
  output logic window_end
);

  import rate_monitor_pkg::*;

  // Value loaded at the start of every window
  localparam timer_t LOAD_VALUE = timer_t'(WINDOW_CYCLES - 1);

  // Cycles left in the current window
  timer_t count;

  // ********************
  // Counter
  // ********************

  // Restart wins over counting, so a fresh window always starts full
  // At zero the counter reloads by itself and the next window follows
  // without a gap
  always_ff @(posedge in_clk) begin
    if (reset) begin
      count <= LOAD_VALUE;
    end else if (restart) begin
      count <= LOAD_VALUE;
    end else if (run) begin
      if (count == '0) begin
        count <= LOAD_VALUE;
      end else begin
        count <= count - timer_t'(1);
      end
    end
  end

  // High for the single cycle that reads zero while running
  // That is the 64th cycle after the load
  assign window_end = run && (count == '0);

endmodule

//--- event_counter.sv
// ********************
// Event counter
// Saturating per-window accumulator with a published report register
// ********************

`timescale 1ns/100ps

module event_counter (
  input  logic                     in_clk,
  input  logic                     reset,
  input  logic                     clear,
  input  logic                     publish,
  input  logic                     event_in,
  output rate_monitor_pkg::report_t report
);

  import rate_monitor_pkg::*;

  // Largest count the accumulator can hold
  localparam rate_t RATE_MAX = '1;

  // Events seen so far in the current window
  rate_t acc;
  // Sticky flag, set once an event arrives with the count already at the top
  logic  overflow;

  // ********************
  // Accumulator
  // ********************

  // Clear comes from the FSM at start, publish at each window boundary
  // On publish the boundary cycle's event opens the next window,
  // so none is dropped between windows
  always_ff @(posedge in_clk) begin
    if (reset) begin
      acc      <= '0;
      overflow <= 1'b0;
    end else if (clear) begin
      acc      <= '0;
      overflow <= 1'b0;
    end else if (publish) begin
      acc      <= rate_t'(event_in);
      overflow <= 1'b0;
    end else if (event_in) begin
      if (acc == RATE_MAX) begin
        // Stick at the top and remember that events were lost
        overflow <= 1'b1;
      end else begin
        acc <= acc + rate_t'(1);
      end
    end
  end

  // ********************
  // Report register
  // ********************

  // Takes the finished window on publish and keeps it until the next one
  // A clear leaves it alone, so a restart still shows the last result
  always_ff @(posedge in_clk) begin
    if (reset) begin
      report <= '0;
    end else if (publish) begin
      report <= {overflow, acc};
    end
  end

endmodule

//--- rate_monitor_fsm.sv
// ********************
// Monitor sequencer
// Steps through idle, measure and publish under the synchronized enable
// ********************

`timescale 1ns/100ps

module rate_monitor_fsm (
  input  logic in_clk,
  input  logic reset,
  input  logic enable,
  input  logic window_end,
  output logic timer_restart,
  output logic timer_run,
  output logic count_clear,
  output logic publish
);

  import rate_monitor_pkg::*;

  monitor_state_t state;
  monitor_state_t state_next;

  // ********************
  // State register
  // ********************

  always_ff @(posedge in_clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // ********************
  // Next state
  // ********************

  // Enable only rises while the FSM sits in idle, since any drop sends it back
  // there, so a high enable in idle is the start condition
  always_comb begin
    state_next    = state;
    timer_restart = 1'b0;
    count_clear   = 1'b0;
    case (state)
      st_idle: begin
        if (enable) begin
          // Load the timer and empty the accumulator in one cycle
          timer_restart = 1'b1;
          count_clear   = 1'b1;
          state_next    = st_measure;
        end
      end
      st_measure: begin
        if (!enable) begin
          state_next = st_idle;
        end else if (window_end) begin
          state_next = st_publish;
        end
      end
      st_publish: begin
        // Exactly one cycle here, the timer is already in the next window
        if (!enable) begin
          state_next = st_idle;
        end else begin
          state_next = st_measure;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  // ********************
  // Decoded outputs
  // ********************

  // Timer keeps running through publish so windows stay back to back
  assign timer_run = (state == st_measure) || (state == st_publish);

  // One pulse per window, the cycle right after window_end
  assign publish = (state == st_publish);

endmodule

//--- rate_monitor_top.sv
// ********************
// Event-rate monitor top level
// Counts events per window in in_clk and reports the rate in out_clk
// ********************

`timescale 1ns/100ps

module rate_monitor_top (
  input  logic                     in_clk,
  input  logic                     reset,
  input  logic                     event_in,
  input  logic                     out_clk,
  input  logic                     out_enable,
  output rate_monitor_pkg::rate_t  out_rate,
  output logic                     out_saturated
);

  import rate_monitor_pkg::*;

  // Enable level after crossing into in_clk
  logic    enable_sync;
  // Reset after crossing into out_clk
  logic    out_reset;
  // FSM controls
  logic    timer_restart;
  logic    timer_run;
  logic    count_clear;
  logic    publish;
  logic    window_end;
  // Report word on either side of the crossing
  report_t report;
  report_t out_report;

  // ********************
  // Clock crossings of control levels
  // ********************

  // The enable comes from the out_clk side and lands two in_clk cycles later
  sync_bits #(
    .NUM_OF_BITS(1)
  ) enable_sync_i (
    .in        (out_enable),
    .out_clk   (in_clk),
    .out_reset (reset),
    .out       (enable_sync)
  );

  // Reset for everything in the out_clk domain
  sync_bits #(
    .NUM_OF_BITS(1)
  ) reset_sync_i (
    .in        (reset),
    .out_clk   (out_clk),
    .out_reset (1'b0),
    .out       (out_reset)
  );

  // ********************
  // Measurement in in_clk
  // ********************

  rate_monitor_fsm fsm_i (
    .in_clk        (in_clk),
    .reset         (reset),
    .enable        (enable_sync),
    .window_end    (window_end),
    .timer_restart (timer_restart),
    .timer_run     (timer_run),
    .count_clear   (count_clear),
    .publish       (publish)
  );

  window_timer timer_i (
    .in_clk     (in_clk),
    .reset      (reset),
    .restart    (timer_restart),
    .run        (timer_run),
    .window_end (window_end)
  );

  event_counter counter_i (
    .in_clk   (in_clk),
    .reset    (reset),
    .clear    (count_clear),
    .publish  (publish),
    .event_in (event_in),
    .report   (report)
  );

  // ********************
  // Report crossing into out_clk
  // ********************

  // Report changes once per window, far slower than the handshake loop
  sync_data #(
    .NUM_OF_BITS ($bits(report_t)),
    .ASYNC_CLK   (1)
  ) report_sync_i (
    .in_clk    (in_clk),
    .in_data   (report),
    .out_clk   (out_clk),
    .out_reset (out_reset),
    .out_data  (out_report)
  );

  // Flag sits above the count in the report word
  assign out_rate      = out_report[RATE_WIDTH-1:0];
  assign out_saturated = out_report[RATE_WIDTH];

endmodule

//--- rate_monitor_checker.sv
// ********************
// Rate monitor checker
// Compares the out_clk results with expected values and holds them for a window
// ********************

`timescale 1ns/100ps

module rate_monitor_checker (
  input  logic                    out_clk,
  input  rate_monitor_pkg::rate_t out_rate,
  input  logic                    out_saturated,
  input  logic                    check_start,
  input  int                      check_row,
  input  rate_monitor_pkg::rate_t exp_rate,
  input  logic                    exp_saturated,
  output logic                    check_done,
  output int                      error_count,
  output int                      check_count
);

  import rate_monitor_pkg::*;

  // One in_clk window measured in out_clk cycles, 10 ns against 14 ns
  localparam int STABLE_CYCLES = (WINDOW_CYCLES * 10) / 14 + 1;

  logic  busy = 1'b0;
  logic  done = 1'b0;
  logic  row_failed = 1'b0;
  int    errors = 0;
  int    checks = 0;
  int    remaining = 0;
  int    row = 0;
  rate_t rate_ref = '0;
  logic  sat_ref = 1'b0;

  // True when both outputs equal the given reference
  function automatic logic values_match(input rate_t rate_exp, input logic sat_exp);
    return (out_rate === rate_exp) && (out_saturated === sat_exp);
  endfunction

  // ********************
  // Compare loop
  // ********************

  // A check starts on the strobe and keeps comparing for one whole window
  // Only the first wrong cycle of a row is reported
  always @(posedge out_clk) begin
    done <= 1'b0;
    if (busy) begin
      if (!row_failed && !values_match(rate_ref, sat_ref)) begin
        $display("mismatch at %0t: row %0d expected rate %0d sat %0b, got rate %0d sat %0b",
                 $time, row, rate_ref, sat_ref, out_rate, out_saturated);
        row_failed <= 1'b1;
        errors     <= errors + 1;
      end
      if (remaining == 0) begin
        busy <= 1'b0;
        done <= 1'b1;
      end else begin
        remaining <= remaining - 1;
      end
    end else if (check_start) begin
      busy       <= 1'b1;
      remaining  <= STABLE_CYCLES;
      row        <= check_row;
      rate_ref   <= exp_rate;
      sat_ref    <= exp_saturated;
      checks     <= checks + 1;
      row_failed <= 1'b0;
      // The strobe cycle itself is the first sample
      if (!values_match(exp_rate, exp_saturated)) begin
        $display("mismatch at %0t: row %0d expected rate %0d sat %0b, got rate %0d sat %0b",
                 $time, check_row, exp_rate, exp_saturated, out_rate, out_saturated);
        row_failed <= 1'b1;
        errors     <= errors + 1;
      end
    end
  end

  assign check_done  = done;
  assign error_count = errors;
  assign check_count = checks;

endmodule

//--- rate_monitor_tb.sv
// ********************
// Rate monitor testbench
// Clocks, reset, stimulus table and driver loop around the monitor
// ********************

`timescale 1ns/100ps

module rate_monitor_tb;

  import rate_monitor_pkg::*;

  localparam int NUM_ROWS = 12;
  // Largest count the report can show
  localparam int RATE_LIMIT = (1 << RATE_WIDTH) - 1;
  // Three windows plus room for the crossing latency
  localparam int SETTLE_CYCLES = 3 * WINDOW_CYCLES + 40;
  // Enough in_clk cycles for the enable to cross and the FSM to react
  localparam int SYNC_CYCLES = 8;
  localparam int DONE_TIMEOUT = 100;
  localparam int MAX_GAP = 40;

  logic  in_clk;
  logic  out_clk;
  logic  reset;
  logic  event_in;
  logic  out_enable;
  rate_t out_rate;
  logic  out_saturated;

  // Checker handshake
  logic  check_start;
  int    check_row;
  rate_t exp_rate;
  logic  exp_saturated;
  logic  check_done;
  int    error_count;
  int    check_count;

  // Event period used by the event driver, 0 stops the events
  int    event_period;
  // Last published result, kept while the monitor is disabled
  rate_t hold_rate;
  logic  hold_sat;
  int    timeouts;

  // ********************
  // Stimulus table
  // ********************

  // Rows: reset state, rates 32 to 1, saturation, recovery, silence,
  // disable with a changed rate, then re-enable
  int   row_period [NUM_ROWS] = '{0, 2, 4, 8, 16, 64, 1, 4, 0, 8, 2, 2};
  logic row_enable [NUM_ROWS] = '{0, 1, 1, 1, 1, 1, 1, 1, 1, 1, 0, 1};

  rate_monitor_top dut_i (
    .in_clk        (in_clk),
    .reset         (reset),
    .event_in      (event_in),
    .out_clk       (out_clk),
    .out_enable    (out_enable),
    .out_rate      (out_rate),
    .out_saturated (out_saturated)
  );

  rate_monitor_checker checker_i (
    .out_clk       (out_clk),
    .out_rate      (out_rate),
    .out_saturated (out_saturated),
    .check_start   (check_start),
    .check_row     (check_row),
    .exp_rate      (exp_rate),
    .exp_saturated (exp_saturated),
    .check_done    (check_done),
    .error_count   (error_count),
    .check_count   (check_count)
  );

  initial begin
    in_clk = 1'b0;
    forever #5 in_clk = ~in_clk;
  end

  initial begin
    out_clk = 1'b0;
    forever #7 out_clk = ~out_clk;
  end

  // Periodic strobes, one every event_period cycles
  // The period is read on the edge, so a change made 1 ns later is picked up next cycle
  initial begin : event_driver
    int period_now;
    int phase;
    phase    = 0;
    event_in = 1'b0;
    forever begin
      @(posedge in_clk);
      period_now = event_period;
      #1;
      if (period_now <= 0) begin
        event_in = 1'b0;
        phase    = 0;
      end else begin
        event_in = (phase == 0);
        phase    = (phase + 1) % period_now;
      end
    end
  end

  // Events per full window for a period, capped at the top of the count range
  function automatic rate_t expected_rate(input int period);
    int events;
    events = (period > 0) ? WINDOW_CYCLES / period : 0;
    return rate_t'((events > RATE_LIMIT) ? RATE_LIMIT : events);
  endfunction

  // Saturation whenever a window holds more events than the count can show
  function automatic logic expected_saturated(input int period);
    return (period > 0) && ((WINDOW_CYCLES / period) > RATE_LIMIT);
  endfunction

  // Applies one table row, lets it settle and hands the expectation to the checker
  task automatic run_row(input int r);
    int waited;
    // Enable first, so a disable takes hold before the events change
    @(posedge out_clk);
    #1 out_enable = row_enable[r];
    repeat (SYNC_CYCLES) @(posedge in_clk);
    #1 event_period = row_period[r];
    repeat (SETTLE_CYCLES) @(posedge in_clk);
    if (row_enable[r]) begin
      hold_rate = expected_rate(row_period[r]);
      hold_sat  = expected_saturated(row_period[r]);
    end
    @(posedge out_clk);
    #1;
    check_row     = r;
    exp_rate      = hold_rate;
    exp_saturated = hold_sat;
    check_start   = 1'b1;
    @(posedge out_clk);
    #1 check_start = 1'b0;
    waited = 0;
    while (!check_done && waited < DONE_TIMEOUT) begin
      @(posedge out_clk);
      #1 waited++;
    end
    if (!check_done) begin
      $display("timeout at %0t: the checker never finished row %0d", $time, r);
      timeouts++;
    end
  endtask

  // ********************
  // Main sequence
  // ********************

  initial begin : main_sequence
    int gap;
    void'($urandom(37872));
    reset         = 1'b1;
    out_enable    = 1'b0;
    event_period  = 0;
    check_start   = 1'b0;
    check_row     = 0;
    exp_rate      = '0;
    exp_saturated = 1'b0;
    hold_rate     = '0;
    hold_sat      = 1'b0;
    timeouts      = 0;
    repeat (3) @(posedge in_clk);
    #1 reset = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (timeouts == 0) begin
        // Random idle gap, it moves the phase of events against the windows
        gap = int'($urandom_range(MAX_GAP, 0));
        repeat (gap) @(posedge in_clk);
        run_row(r);
      end
    end
    $display("errors %0d, timeouts %0d, checks %0d of %0d",
             error_count, timeouts, check_count, NUM_ROWS);
    if (error_count == 0 && timeouts == 0 && check_count == NUM_ROWS) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- rate_monitor_top.f
rate_monitor_pkg.sv
sync_bits.sv
sync_data.sv
window_timer.sv
event_counter.sv
rate_monitor_fsm.sv
rate_monitor_top.sv
rate_monitor_checker.sv
rate_monitor_tb.sv

//--- Makefile
# Verilator build and run of the rate monitor testbench

LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module rate_monitor_tb \
		-f rate_monitor_top.f -o rate_monitor_sim
	./obj_dir/rate_monitor_sim | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
